/* rtl/manycore_io_pkg.sv */
package manycore_io_pkg;

   // mesh of tiles, the I/O row sits below it at y = NUM_ROWS
   localparam int NUM_COLS  = 4;
   localparam int NUM_ROWS  = 2;
   localparam int NUM_TILES = NUM_COLS * NUM_ROWS;
   localparam int X_W       = 2;
   localparam int Y_W       = 2;

   localparam int ADDR_W = 12;
   localparam int DATA_W = 32;
   localparam int EXIT_W = 24;

   // program image
   localparam int                IMAGE_WORDS = 16;
   localparam int                WORD_W      = $clog2(IMAGE_WORDS);
   localparam logic [ADDR_W-1:0] IMAGE_BASE  = 12'h000;

   // tile start word and the I/O finish word
   localparam logic [ADDR_W-1:0] GO_ADDR     = 12'hffc;
   localparam logic [DATA_W-1:0] GO_DATA     = 32'h0000_0001;
   localparam logic [ADDR_W-1:0] FINISH_ADDR = 12'hfe0;

   // out-credit depths, column 0 carries the loader
   localparam int LOADER_CREDITS = 8;
   localparam int COL_CREDITS    = 4;
   localparam int CRED_W         = $clog2(LOADER_CREDITS + 1);

   localparam int MAX_CYCLES = 20000;
   localparam int CYCLE_W    = 24;
   localparam int TILE_CNT_W = $clog2(NUM_TILES + 1);

   // loader phases
   localparam logic [1:0] PH_IDLE  = 2'd0;
   localparam logic [1:0] PH_IMAGE = 2'd1;
   localparam logic [1:0] PH_GO    = 2'd2;
   localparam logic [1:0] PH_DONE  = 2'd3;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [X_W-1:0]    x_dst;
      logic [Y_W-1:0]    y_dst;
      logic [X_W-1:0]    x_src;
      logic [Y_W-1:0]    y_src;
   } io_packet_s;

   typedef struct packed {
      logic       v;
      io_packet_s pkt;
   } io_link_fwd_s;

   typedef struct packed {
      logic ready;
      logic credit;
   } io_link_rev_s;

   // finish word layout; rsvd pads it to a full data word
   typedef struct packed {
      logic              status;
      logic [2:0]        rsvd;
      logic [X_W-1:0]    tile_x;
      logic [Y_W-1:0]    tile_y;
      logic [EXIT_W-1:0] exit_code;
   } finish_word_s;

   typedef union packed {
      logic [DATA_W-1:0] raw;
      finish_word_s      fin;
   } io_payload_u;

   typedef struct packed {
      logic              valid;
      logic [X_W-1:0]    x;
      logic [Y_W-1:0]    y;
      logic [EXIT_W-1:0] code;
   } finish_rpt_s;

endpackage

/* rtl/io_program_rom.sv */
`timescale 1ns/10ps

module io_program_rom
  (
   input  logic [manycore_io_pkg::WORD_W-1:0] addr_i,
   output logic [manycore_io_pkg::DATA_W-1:0] data_o
  );

   import manycore_io_pkg::*;

   // one entry per image word
   logic [DATA_W-1:0] mem [IMAGE_WORDS];

   // image is fixed at build time
   initial
   begin
      $readmemh("program.hex", mem);
   end

   // asynchronous read, the loader sees the word in the same cycle
   assign data_o = mem[addr_i];

endmodule

/* rtl/spmd_loader.sv */
`timescale 1ns/10ps

module spmd_loader
  (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   output logic [manycore_io_pkg::WORD_W-1:0]  rom_addr_o,
   input  logic [manycore_io_pkg::DATA_W-1:0]  rom_data_i,
   output manycore_io_pkg::io_packet_s         pkt_o,
   output logic                                v_o,
   input  logic                                ready_i,
   output logic                                load_done_o
  );

   import manycore_io_pkg::*;

   logic [1:0]        phase_q;
   logic [X_W-1:0]    x_q;
   logic [Y_W-1:0]    y_q;
   logic [WORD_W-1:0] word_q;
   logic              fire;
   logic              last_word;
   logic              last_x;
   logic              last_y;

   assign fire      = v_o & ready_i;
   assign last_word = (word_q == WORD_W'(IMAGE_WORDS - 1));
   assign last_x    = (x_q == X_W'(NUM_COLS - 1));
   assign last_y    = (y_q == Y_W'(NUM_ROWS - 1));

   // word is the inner loop, then x, then y
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         phase_q <= PH_IDLE;
         x_q     <= '0;
         y_q     <= '0;
         word_q  <= '0;
      end
      else
      begin
         case (phase_q)
            PH_IDLE:
            begin
               phase_q <= PH_IMAGE;
            end
            PH_IMAGE:
            begin
               if (fire)
               begin
                  word_q <= word_q + 1'b1;
                  if (last_word)
                  begin
                     word_q <= '0;
                     x_q    <= x_q + 1'b1;
                     if (last_x)
                     begin
                        x_q <= '0;
                        y_q <= y_q + 1'b1;
                        if (last_y)
                        begin
                           y_q     <= '0;
                           phase_q <= PH_GO;
                        end
                     end
                  end
               end
            end
            PH_GO:
            begin
               if (fire)
               begin
                  x_q <= x_q + 1'b1;
                  if (last_x)
                  begin
                     x_q <= '0;
                     y_q <= y_q + 1'b1;
                     if (last_y)
                     begin
                        phase_q <= PH_DONE;
                     end
                  end
               end
            end
            default:
            begin
               phase_q <= phase_q;
            end
         endcase
      end
   end

   assign rom_addr_o  = word_q;
   assign v_o         = (phase_q == PH_IMAGE) || (phase_q == PH_GO);
   assign load_done_o = (phase_q == PH_DONE);

   // packet is built from the counters only, so it holds while stalled
   always_comb
   begin
      pkt_o.x_dst = x_q;
      pkt_o.y_dst = y_q;
      pkt_o.x_src = '0;
      pkt_o.y_src = Y_W'(NUM_ROWS);
      if (phase_q == PH_GO)
      begin
         pkt_o.addr = GO_ADDR;
         pkt_o.data = GO_DATA;
      end
      else
      begin
         pkt_o.addr = IMAGE_BASE + ADDR_W'(word_q);
         pkt_o.data = rom_data_i;
      end
   end

   // a stalled packet must not change until the link takes it
   a_hold_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      v_o && !ready_i |=> v_o && $stable(pkt_o));

endmodule

/* rtl/io_link_endpoint.sv */
`timescale 1ns/10ps

module io_link_endpoint
  (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  logic [manycore_io_pkg::X_W-1:0]   col_i,
   input  manycore_io_pkg::io_link_fwd_s     link_fwd_i,
   input  manycore_io_pkg::io_link_rev_s     link_rev_i,
   output manycore_io_pkg::io_link_fwd_s     link_fwd_o,
   output manycore_io_pkg::io_link_rev_s     link_rev_o,
   input  manycore_io_pkg::io_packet_s       pt_pkt_i,
   input  logic                              pt_v_i,
   output logic                              pt_ready_o,
   output manycore_io_pkg::finish_rpt_s      rpt_o,
   output logic                              bad_req_o
  );

   import manycore_io_pkg::*;

   logic              pt_en;
   logic [CRED_W-1:0] cred_max;
   logic [CRED_W-1:0] cred_q;
   logic              have_cred;
   logic              send;
   logic              acc_q;
   logic              fin_q;
   io_payload_u       pay_d;
   io_payload_u       pay_q;

   // column 0 forwards loader traffic and gets the deeper credit pool
   assign pt_en     = (col_i == '0);
   assign cred_max  = pt_en ? CRED_W'(LOADER_CREDITS) : CRED_W'(COL_CREDITS);
   assign have_cred = (cred_q != '0);

   assign link_fwd_o.v   = pt_en & pt_v_i & have_cred;
   assign link_fwd_o.pkt = pt_pkt_i;
   assign pt_ready_o     = pt_en & link_rev_i.ready & have_cred;
   assign send           = link_fwd_o.v & link_rev_i.ready;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         cred_q <= cred_max;
      end
      else
      begin
         cred_q <= cred_q - CRED_W'(send) + CRED_W'(link_rev_i.credit);
      end
   end

   // incoming requests are always accepted and credited one cycle later
   assign link_rev_o.ready = 1'b1;
   assign pay_d.raw        = link_fwd_i.pkt.data;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         acc_q <= 1'b0;
         fin_q <= 1'b0;
      end
      else
      begin
         acc_q <= link_fwd_i.v;
         fin_q <= (link_fwd_i.pkt.addr == FINISH_ADDR);
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (link_fwd_i.v)
      begin
         pay_q <= pay_d;
      end
   end

   assign link_rev_o.credit = acc_q;

   // finish word seen through its decoded view
   assign rpt_o.valid = acc_q & fin_q;
   assign rpt_o.x     = pay_q.fin.tile_x;
   assign rpt_o.y     = pay_q.fin.tile_y;
   assign rpt_o.code  = pay_q.fin.exit_code;
   assign bad_req_o   = acc_q & ~fin_q;

   // an underflow wraps above the depth and fails here too
   a_cred_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cred_q <= cred_max);

   // tile side must not return a credit with nothing outstanding
   a_cred_return: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      link_rev_i.credit && !send |-> cred_q < cred_max);

   // only column 0 may be offered loader traffic
   a_col0_only: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      col_i != '0 |-> !pt_v_i);

endmodule

/* rtl/io_finish_monitor.sv */
`timescale 1ns/10ps

module io_finish_monitor
  (
   input  logic                                                    clk_i,
   input  logic                                                    rst_n_i,
   input  manycore_io_pkg::finish_rpt_s [manycore_io_pkg::NUM_COLS-1:0] rpt_i,
   input  logic [manycore_io_pkg::NUM_COLS-1:0]                    bad_i,
   output logic                                                    done_o,
   output logic                                                    timeout_o,
   output logic                                                    bad_req_o,
   output logic [manycore_io_pkg::DATA_W-1:0]                      signature_o,
   output logic [manycore_io_pkg::CYCLE_W-1:0]                     finish_cycle_o
  );

   import manycore_io_pkg::*;

   logic [CYCLE_W-1:0]    cycle_q;
   logic [CYCLE_W-1:0]    fin_cycle_q;
   logic [TILE_CNT_W-1:0] cnt_q;
   logic [TILE_CNT_W-1:0] cnt_d;
   logic [DATA_W-1:0]     sig_q;
   logic [DATA_W-1:0]     sig_d;
   logic [NUM_TILES-1:0]  seen_q;
   logic [NUM_TILES-1:0]  seen_set;
   logic                  done_q;
   logic                  timeout_q;
   logic                  frozen;

   function automatic int tile_idx(input logic [X_W-1:0] x, input logic [Y_W-1:0] y);
      return int'(y) * NUM_COLS + int'(x);
   endfunction

   // several columns may report in the same cycle
   always_comb
   begin
      cnt_d    = cnt_q;
      sig_d    = sig_q;
      seen_set = '0;
      for (int c = 0; c < NUM_COLS; c++)
      begin
         if (rpt_i[c].valid)
         begin
            cnt_d = cnt_d + 1'b1;
            sig_d = sig_d ^ DATA_W'(rpt_i[c].code);
            seen_set[tile_idx(rpt_i[c].x, rpt_i[c].y)] = 1'b1;
         end
      end
   end

   assign frozen = done_q | timeout_q;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         cycle_q     <= '0;
         fin_cycle_q <= '0;
         cnt_q       <= '0;
         sig_q       <= '0;
         seen_q      <= '0;
         done_q      <= 1'b0;
         timeout_q   <= 1'b0;
      end
      else if (!frozen)
      begin
         cycle_q <= cycle_q + 1'b1;
         cnt_q   <= cnt_d;
         sig_q   <= sig_d;
         seen_q  <= seen_q | seen_set;
         if (cnt_d == TILE_CNT_W'(NUM_TILES))
         begin
            done_q      <= 1'b1;
            fin_cycle_q <= cycle_q;
         end
         else if (cycle_q == CYCLE_W'(MAX_CYCLES - 1))
         begin
            timeout_q <= 1'b1;
         end
      end
   end

   assign done_o         = done_q;
   assign timeout_o      = timeout_q;
   assign bad_req_o      = |bad_i;
   assign signature_o    = sig_q;
   assign finish_cycle_o = fin_cycle_q;

   // each tile finishes once, whichever column it reports on
   for (genvar c = 0; c < NUM_COLS; c++)
   begin : g_once
      a_report_once: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         rpt_i[c].valid |-> !seen_q[tile_idx(rpt_i[c].x, rpt_i[c].y)]);
   end

endmodule

/* rtl/manycore_io_complex.sv */
`timescale 1ns/10ps

module manycore_io_complex
  (
   input  logic                                                      clk_i,
   input  logic                                                      rst_n_i,
   input  manycore_io_pkg::io_link_fwd_s [manycore_io_pkg::NUM_COLS-1:0] link_fwd_i,
   input  manycore_io_pkg::io_link_rev_s [manycore_io_pkg::NUM_COLS-1:0] link_rev_i,
   output manycore_io_pkg::io_link_fwd_s [manycore_io_pkg::NUM_COLS-1:0] link_fwd_o,
   output manycore_io_pkg::io_link_rev_s [manycore_io_pkg::NUM_COLS-1:0] link_rev_o,
   output logic                                                      done_o,
   output logic                                                      timeout_o,
   output logic                                                      bad_req_o,
   output logic [manycore_io_pkg::DATA_W-1:0]                        signature_o,
   output logic [manycore_io_pkg::CYCLE_W-1:0]                       finish_cycle_o
  );

   import manycore_io_pkg::*;

   logic [WORD_W-1:0]          rom_addr;
   logic [DATA_W-1:0]          rom_data;
   io_packet_s                 loader_pkt;
   logic                       loader_v;
   logic                       loader_ready;
   logic [NUM_COLS-1:0]        pt_ready;
   logic [NUM_COLS-1:0]        bad;
   finish_rpt_s [NUM_COLS-1:0] rpt;

   io_program_rom u_rom
     (
      .addr_i (rom_addr),
      .data_o (rom_data)
     );

   spmd_loader u_loader
     (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .rom_addr_o  (rom_addr),
      .rom_data_i  (rom_data),
      .pkt_o       (loader_pkt),
      .v_o         (loader_v),
      .ready_i     (loader_ready),
      .load_done_o ()
     );

   // the loader reaches column 0 only and the other endpoints get idle inputs
   for (genvar c = 0; c < NUM_COLS; c++)
   begin : g_col
      io_link_endpoint u_ep
        (
         .clk_i      (clk_i),
         .rst_n_i    (rst_n_i),
         .col_i      (X_W'(c)),
         .link_fwd_i (link_fwd_i[c]),
         .link_rev_i (link_rev_i[c]),
         .link_fwd_o (link_fwd_o[c]),
         .link_rev_o (link_rev_o[c]),
         .pt_pkt_i   ((c == 0) ? loader_pkt : io_packet_s'('0)),
         .pt_v_i     ((c == 0) ? loader_v : 1'b0),
         .pt_ready_o (pt_ready[c]),
         .rpt_o      (rpt[c]),
         .bad_req_o  (bad[c])
        );
   end

   // only column 0 can raise pass-through ready
   assign loader_ready = |pt_ready;

   io_finish_monitor u_mon
     (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .rpt_i          (rpt),
      .bad_i          (bad),
      .done_o         (done_o),
      .timeout_o      (timeout_o),
      .bad_req_o      (bad_req_o),
      .signature_o    (signature_o),
      .finish_cycle_o (finish_cycle_o)
     );

endmodule

/* tb/tile_array_model.sv */
`timescale 1ns/10ps

module tile_array_model
  (
   input  logic                                                          clk_i,
   input  logic                                                          rst_n_i,
   input  manycore_io_pkg::io_link_fwd_s [manycore_io_pkg::NUM_COLS-1:0] dn_fwd_i,
   output manycore_io_pkg::io_link_rev_s [manycore_io_pkg::NUM_COLS-1:0] dn_rev_o,
   output manycore_io_pkg::io_link_fwd_s [manycore_io_pkg::NUM_COLS-1:0] up_fwd_o,
   input  manycore_io_pkg::io_link_rev_s [manycore_io_pkg::NUM_COLS-1:0] up_rev_i,
   input  logic                                                          send_bad_i
  );

   import manycore_io_pkg::*;

   logic [DATA_W-1:0]    word_xor [NUM_TILES];
   logic [NUM_TILES-1:0] go_seen;
   logic [NUM_TILES-1:0] started;
   logic [NUM_TILES-1:0] finished;
   int                   wait_cnt [NUM_TILES];
   int                   rx_cnt [NUM_COLS];
   int                   cred_ret_cnt [NUM_COLS];
   int                   up_sent [NUM_COLS];
   int                   up_cred_cnt [NUM_COLS];
   logic                 bad_sent;

   // finish request of tile t, exit code folds its image with its index
   function automatic io_packet_s finish_pkt(input int t);
      finish_word_s fw;
      io_payload_u  pay;
      io_packet_s   p;
      fw.status    = 1'b1;
      fw.rsvd      = '0;
      fw.tile_x    = X_W'(t % NUM_COLS);
      fw.tile_y    = Y_W'(t / NUM_COLS);
      fw.exit_code = EXIT_W'(word_xor[t] ^ DATA_W'(t + 1));
      pay.fin      = fw;
      p.addr       = FINISH_ADDR;
      p.data       = pay.raw;
      p.x_dst      = fw.tile_x;
      p.y_dst      = Y_W'(NUM_ROWS);
      p.x_src      = fw.tile_x;
      p.y_src      = fw.tile_y;
      return p;
   endfunction

   function automatic int credit_depth(input int c);
      return (c == 0) ? LOADER_CREDITS : COL_CREDITS;
   endfunction

   initial
   begin
      dn_rev_o = '0;
      up_fwd_o = '0;
   end

   // link levels are settled here, the transfer itself is on the next rising edge
   always @(negedge clk_i)
   begin
      int t;
      if (!rst_n_i)
      begin
         go_seen = '0;
         for (int i = 0; i < NUM_TILES; i++)
         begin
            word_xor[i] = '0;
         end
         for (int c = 0; c < NUM_COLS; c++)
         begin
            rx_cnt[c]      = 0;
            up_cred_cnt[c] = 0;
         end
      end
      else
      begin
         for (int c = 0; c < NUM_COLS; c++)
         begin
            if (dn_fwd_i[c].v && dn_rev_o[c].ready)
            begin
               rx_cnt[c]++;
               t = int'(dn_fwd_i[c].pkt.y_dst) * NUM_COLS + int'(dn_fwd_i[c].pkt.x_dst);
               if (t < NUM_TILES)
               begin
                  if (dn_fwd_i[c].pkt.addr == GO_ADDR)
                     go_seen[t] = 1'b1;
                  else
                     word_xor[t] = word_xor[t] ^ dn_fwd_i[c].pkt.data;
               end
            end
            if (up_rev_i[c].credit)
               up_cred_cnt[c]++;
         end
      end
   end

   always @(posedge clk_i)
   begin
      int   t;
      logic sending;
      io_packet_s bad_pkt;
      if (!rst_n_i)
      begin
         dn_rev_o <= '0;
         up_fwd_o <= '0;
         started  <= '0;
         finished <= '0;
         bad_sent <= 1'b0;
         for (int i = 0; i < NUM_TILES; i++)
         begin
            wait_cnt[i] <= 0;
         end
         for (int c = 0; c < NUM_COLS; c++)
         begin
            cred_ret_cnt[c] <= 0;
            up_sent[c]      <= 0;
         end
      end
      else
      begin
         // random ready, and credits come back after a random delay
         for (int c = 0; c < NUM_COLS; c++)
         begin
            dn_rev_o[c].ready <= (($urandom % 4) != 0);
            if ((rx_cnt[c] > cred_ret_cnt[c]) && (($urandom % 3) == 0))
            begin
               dn_rev_o[c].credit <= 1'b1;
               cred_ret_cnt[c]    <= cred_ret_cnt[c] + 1;
            end
            else
            begin
               dn_rev_o[c].credit <= 1'b0;
            end
         end
         for (int i = 0; i < NUM_TILES; i++)
         begin
            if (go_seen[i] && !started[i])
            begin
               started[i]  <= 1'b1;
               wait_cnt[i] <= 4 + int'($urandom % 60);
            end
            else if (started[i] && (wait_cnt[i] > 0))
            begin
               wait_cnt[i] <= wait_cnt[i] - 1;
            end
         end
         // one request per column and cycle, never beyond the column's credits
         for (int c = 0; c < NUM_COLS; c++)
         begin
            sending = 1'b0;
            up_fwd_o[c].v <= 1'b0;
            for (int r = 0; r < NUM_ROWS; r++)
            begin
               t = r * NUM_COLS + c;
               if (!sending && started[t] && (wait_cnt[t] == 0) && !finished[t] &&
                   ((up_sent[c] - up_cred_cnt[c]) < credit_depth(c)))
               begin
                  up_fwd_o[c].v   <= 1'b1;
                  up_fwd_o[c].pkt <= finish_pkt(t);
                  finished[t]     <= 1'b1;
                  up_sent[c]      <= up_sent[c] + 1;
                  sending = 1'b1;
               end
            end
            // plain store to a non-finish address on column 2
            if ((c == 2) && !sending && send_bad_i && !bad_sent)
            begin
               bad_pkt.addr    = 12'h100;
               bad_pkt.data    = 32'h5a5a_0c0d;
               bad_pkt.x_dst   = X_W'(c);
               bad_pkt.y_dst   = Y_W'(NUM_ROWS);
               bad_pkt.x_src   = X_W'(c);
               bad_pkt.y_src   = '0;
               up_fwd_o[c].v   <= 1'b1;
               up_fwd_o[c].pkt <= bad_pkt;
               up_sent[c]      <= up_sent[c] + 1;
               bad_sent        <= 1'b1;
            end
         end
      end
   end

endmodule

/* tb/tb_manycore_io.sv */
`timescale 1ns/10ps

module tb_manycore_io;

   import manycore_io_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int LOAD_XFERS = NUM_ROWS * NUM_COLS * (IMAGE_WORDS + 1);
   // credits return about every third cycle, ready drops one cycle in four
   localparam int STALL_FACTOR    = 8;
   localparam int FINISH_SLACK    = 300;
   localparam int WATCHDOG_CYCLES = LOAD_XFERS * STALL_FACTOR + FINISH_SLACK;
   localparam int NUM_TESTS       = 5;

   logic clk      = 1'b0;
   logic rst_n    = 1'b0;
   logic send_bad = 1'b0;

   io_link_fwd_s [NUM_COLS-1:0] link_fwd_in;
   io_link_rev_s [NUM_COLS-1:0] link_rev_in;
   io_link_fwd_s [NUM_COLS-1:0] link_fwd_out;
   io_link_rev_s [NUM_COLS-1:0] link_rev_out;
   logic                        done;
   logic                        timeout;
   logic                        bad_req;
   logic [DATA_W-1:0]           signature;
   logic [CYCLE_W-1:0]          finish_cycle;

   logic [DATA_W-1:0] image [IMAGE_WORDS];
   io_packet_s        exp_pkts [LOAD_XFERS];
   logic [DATA_W-1:0] exp_sig;
   int                exp_idx;
   int                img_cnt [NUM_TILES];
   int                xfer0;
   int                cred0;
   int                req_cnt [NUM_COLS];
   int                crd_cnt [NUM_COLS];
   int                bad_cnt;
   int                mon_errs [NUM_TESTS];
   int                chk_errs [NUM_TESTS];

   always #(CLK_PERIOD / 2) clk = ~clk;

   manycore_io_complex dut_i
     (
      .clk_i          (clk),
      .rst_n_i        (rst_n),
      .link_fwd_i     (link_fwd_in),
      .link_rev_i     (link_rev_in),
      .link_fwd_o     (link_fwd_out),
      .link_rev_o     (link_rev_out),
      .done_o         (done),
      .timeout_o      (timeout),
      .bad_req_o      (bad_req),
      .signature_o    (signature),
      .finish_cycle_o (finish_cycle)
     );

   tile_array_model tiles
     (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .dn_fwd_i   (link_fwd_out),
      .dn_rev_o   (link_rev_in),
      .up_fwd_o   (link_fwd_in),
      .up_rev_i   (link_rev_out),
      .send_bad_i (send_bad)
     );

   task automatic show_mismatch(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      $display("ERR t=%0t %s expected=%0h got=%0h", $time, name, expected, actual);
   endtask

   task automatic print_result(input string name, input int n_err);
      if (n_err == 0)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, n_err);
   endtask

   function automatic io_packet_s loader_store(input logic [ADDR_W-1:0] addr,
                                               input logic [DATA_W-1:0] data,
                                               input int x, input int y);
      io_packet_s p;
      p.addr  = addr;
      p.data  = data;
      p.x_dst = X_W'(x);
      p.y_dst = Y_W'(y);
      p.x_src = '0;
      p.y_src = Y_W'(NUM_ROWS);
      return p;
   endfunction

   // link monitor, every level here was set at the last rising edge
   always @(negedge clk)
   begin
      int t;
      if (rst_n)
      begin
         if (link_fwd_out[0].v && link_rev_in[0].ready)
         begin
            xfer0++;
            assert ((xfer0 - cred0) <= LOADER_CREDITS) else
            begin
               $display("%0t: column 0 has %0d packets unreturned, above its credit depth",
                        $time, xfer0 - cred0);
               mon_errs[1]++;
            end
            assert (exp_idx < LOAD_XFERS) else
            begin
               $display("%0t: column 0 sent a packet after the load was complete", $time);
               mon_errs[0]++;
            end
            if (exp_idx < LOAD_XFERS)
            begin
               assert (link_fwd_out[0].pkt == exp_pkts[exp_idx]) else
               begin
                  show_mismatch("link_fwd_o[0].pkt", 64'(exp_pkts[exp_idx]),
                                64'(link_fwd_out[0].pkt));
                  mon_errs[0]++;
               end
               exp_idx++;
            end
            t = int'(link_fwd_out[0].pkt.y_dst) * NUM_COLS + int'(link_fwd_out[0].pkt.x_dst);
            if ((t < NUM_TILES) && (link_fwd_out[0].pkt.addr == GO_ADDR))
            begin
               assert (img_cnt[t] == IMAGE_WORDS) else
               begin
                  show_mismatch($sformatf("image stores of tile %0d", t), 64'(IMAGE_WORDS),
                                64'(img_cnt[t]));
                  mon_errs[0]++;
               end
            end
            else if (t < NUM_TILES)
            begin
               img_cnt[t]++;
            end
         end
         if (link_rev_in[0].credit)
            cred0++;
         for (int c = 1; c < NUM_COLS; c++)
         begin
            assert (!link_fwd_out[c].v) else
            begin
               $display("%0t: column %0d sent a packet towards the tiles", $time, c);
               mon_errs[1]++;
            end
         end
         for (int c = 0; c < NUM_COLS; c++)
         begin
            if (link_fwd_in[c].v)
            begin
               assert (link_rev_out[c].ready) else
               begin
                  $display("%0t: column %0d dropped ready under a request", $time, c);
                  mon_errs[2]++;
               end
               req_cnt[c]++;
            end
            if (link_rev_out[c].credit)
               crd_cnt[c]++;
            assert (crd_cnt[c] <= req_cnt[c]) else
            begin
               $display("%0t: column %0d returned a credit with no request", $time, c);
               mon_errs[2]++;
            end
         end
         if (bad_req)
            bad_cnt++;
         assert (!timeout) else
         begin
            $display("%0t: timeout_o is high", $time);
            mon_errs[4]++;
         end
      end
   end

   initial
   begin
      int                n;
      int                wait_cycles;
      int                total;
      int                failed;
      logic [DATA_W-1:0] img_xor;
      logic [DATA_W-1:0] sig_before;
      void'($urandom(32'hd0a5));
      $readmemh("program.hex", image);
      // words innermost, then x, then y, and the go stores at the end
      n       = 0;
      img_xor = '0;
      for (int w = 0; w < IMAGE_WORDS; w++)
      begin
         img_xor = img_xor ^ image[w];
      end
      for (int y = 0; y < NUM_ROWS; y++)
      begin
         for (int x = 0; x < NUM_COLS; x++)
         begin
            for (int w = 0; w < IMAGE_WORDS; w++)
            begin
               exp_pkts[n] = loader_store(IMAGE_BASE + ADDR_W'(w), image[w], x, y);
               n++;
            end
         end
      end
      for (int y = 0; y < NUM_ROWS; y++)
      begin
         for (int x = 0; x < NUM_COLS; x++)
         begin
            exp_pkts[n] = loader_store(GO_ADDR, GO_DATA, x, y);
            n++;
         end
      end
      exp_sig = '0;
      for (int t = 0; t < NUM_TILES; t++)
      begin
         exp_sig = exp_sig ^ DATA_W'(EXIT_W'(img_xor ^ DATA_W'(t + 1)));
      end

      repeat (10) @(posedge clk);
      rst_n <= 1'b1;

      while (exp_idx < LOAD_XFERS) @(posedge clk);
      print_result("image and go stores", mon_errs[0] + chk_errs[0]);
      print_result("column 0 credits", mon_errs[1] + chk_errs[1]);

      while (!done && !timeout) @(negedge clk);
      assert (done) else
      begin
         $display("%0t: timeout_o rose before all tiles finished", $time);
         chk_errs[3]++;
      end
      assert (signature == exp_sig) else
      begin
         show_mismatch("signature_o", 64'(exp_sig), 64'(signature));
         chk_errs[3]++;
      end
      assert (finish_cycle != '0) else
      begin
         $display("%0t: finish_cycle_o is zero after done", $time);
         chk_errs[3]++;
      end
      assert (bad_cnt == 0) else
      begin
         $display("%0t: bad_req_o pulsed during the normal run", $time);
         chk_errs[3]++;
      end
      print_result("finish and signature", mon_errs[3] + chk_errs[3]);

      // bad store on column 2 once everything is done
      sig_before = signature;
      @(posedge clk);
      send_bad <= 1'b1;
      wait_cycles = 0;
      while ((bad_cnt == 0) && (wait_cycles < 20))
      begin
         @(posedge clk);
         wait_cycles++;
      end
      send_bad <= 1'b0;
      assert (bad_cnt == 1) else
      begin
         $display("%0t: bad_req_o did not pulse once for the bad store", $time);
         chk_errs[4]++;
      end
      repeat (4) @(negedge clk);
      assert (signature == sig_before) else
      begin
         show_mismatch("signature_o", 64'(sig_before), 64'(signature));
         chk_errs[4]++;
      end
      print_result("bad request", mon_errs[4] + chk_errs[4]);

      @(posedge clk);
      for (int c = 0; c < NUM_COLS; c++)
      begin
         assert (crd_cnt[c] == req_cnt[c]) else
         begin
            show_mismatch($sformatf("link_rev_o[%0d].credit count", c), 64'(req_cnt[c]),
                          64'(crd_cnt[c]));
            chk_errs[2]++;
         end
      end
      assert ((req_cnt[0] + req_cnt[1] + req_cnt[2] + req_cnt[3]) == NUM_TILES + 1) else
      begin
         $display("%0t: tiles sent the wrong number of requests", $time);
         chk_errs[2]++;
      end
      print_result("request credits", mon_errs[2] + chk_errs[2]);

      total  = 0;
      failed = 0;
      for (int i = 0; i < NUM_TESTS; i++)
      begin
         total = total + mon_errs[i] + chk_errs[i];
         if ((mon_errs[i] + chk_errs[i]) != 0)
            failed++;
      end
      $display("%0d tests, %0d with errors, %0d errors in total", NUM_TESTS, failed, total);
      if (total == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   // bound from the load length with the random stalls counted in
   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles before the run completed", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* program.hex */
// one 32-bit image word per line, word 0 first
13000513
00a00593
00b50633
fe010113
00112e23
00812c23
02010413
3c8f91a7
0000006f
deadbeef
7f3e2d1c
a5a55a5a
00c58693
01f2e4b6
c0ffee00
00008067

/* build.f */
rtl/manycore_io_pkg.sv
rtl/io_program_rom.sv
rtl/spmd_loader.sv
rtl/io_link_endpoint.sv
rtl/io_finish_monitor.sv
rtl/manycore_io_complex.sv
tb/tile_array_model.sv
tb/tb_manycore_io.sv

/* Makefile */
# Verilator build and run of the host I/O testbench

VERILATOR ?= verilator
TOP       ?= tb_manycore_io
RTL_TOP   ?= manycore_io_complex
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Simulation passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
